//--- source/ice_pkg.sv
package ice_pkg;

	// UART bit period in clocks, fixed baud
	localparam int CLKS_PER_BIT = 16;
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	// Last count of a bit period, and the mid-bit sample point
	localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [BIT_CNT_W-1:0] BIT_MID = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);

	// Responders on the slave bus, index 0 basics, index 1 gpio
	localparam int NUM_SLAVES = 2;

	localparam int GPIO_WIDTH = 8;

	// Longer host payloads are dropped with a NAK
	localparam logic [7:0] MAX_PAYLOAD = 8'd8;

	// Power of two depths
	localparam int RX_FIFO_DEPTH = 32;
	localparam int EVENT_FIFO_DEPTH = 4;

	// Version query answer
	localparam logic [7:0] VERSION_MAJOR = 8'h03;
	localparam logic [7:0] VERSION_MINOR = 8'h01;

	// Frame type codes
	localparam logic [7:0] TYPE_ACK = 8'h00;
	localparam logic [7:0] TYPE_NAK = 8'h01;
	localparam logic [7:0] TYPE_VERSION = "V";
	localparam logic [7:0] TYPE_POWER = "p";
	localparam logic [7:0] TYPE_GPIO = "g";
	localparam logic [7:0] TYPE_EVENT = "e";

	// GPIO input-change event
	// [1] time tag from the event counter, [0] masked pin values
	typedef logic [1:0][GPIO_WIDTH-1:0] gpio_event_t;

endpackage

//--- source/uart.sv
`timescale 1ns/1ps

module uart import ice_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic rx_in,
	output logic tx_out,
	input logic tx_latch,
	input logic [7:0] tx_data,
	output logic tx_empty,
	output logic [7:0] rx_data,
	output logic rx_latch
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t rx_state;
	logic [1:0] rx_sync;
	logic [BIT_CNT_W-1:0] rx_cnt;
	logic [2:0] rx_bit;
	logic [7:0] rx_shift;

	logic [9:0] tx_shift;
	logic [3:0] tx_bits;
	logic [BIT_CNT_W-1:0] tx_cnt;

	// Shift register holds the last byte until the next frame starts shifting
	assign rx_data = rx_shift;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_sync <= 2'b11;
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_latch <= 1'b0;
		end else begin
			// Two flops against metastability on the pad
			rx_sync <= {rx_sync[0], rx_in};
			rx_latch <= 1'b0;
			case (rx_state)
				RX_IDLE: begin
					rx_cnt <= '0;
					if (!rx_sync[1])
						rx_state <= RX_START;
				end
				RX_START: begin
					// Line must still be low at mid-bit, else it was a glitch
					if (rx_cnt == BIT_MID) begin
						rx_cnt <= '0;
						rx_bit <= '0;
						rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (rx_cnt == BIT_LAST) begin
						rx_cnt <= '0;
						// LSB arrives first
						rx_shift <= {rx_sync[1], rx_shift[7:1]};
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= RX_STOP;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				default: begin
					if (rx_cnt == BIT_LAST) begin
						rx_state <= RX_IDLE;
						// Framing error drops the byte
						rx_latch <= rx_sync[1];
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// Transmitter idle when no bits are left to shift
	assign tx_empty = (tx_bits == 4'd0);
	assign tx_out = tx_shift[0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx_shift <= '1;
			tx_bits <= '0;
			tx_cnt <= '0;
		end else if (tx_empty) begin
			if (tx_latch) begin
				// Stop, data, start
				tx_shift <= {1'b1, tx_data, 1'b0};
				tx_bits <= 4'd10;
				tx_cnt <= '0;
			end
		end else if (tx_cnt == BIT_LAST) begin
			tx_cnt <= '0;
			tx_shift <= {1'b1, tx_shift[9:1]};
			tx_bits <= tx_bits - 1'b1;
		end else begin
			tx_cnt <= tx_cnt + 1'b1;
		end
	end

endmodule

//--- source/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	input payload_t in_data,
	input logic in_latch,
	output payload_t out_data,
	input logic out_latch,
	output logic out_valid,
	output logic full
);

	payload_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0] count;
	logic wr_en;
	logic rd_en;

	// DEPTH is a power of two, so the count MSB alone marks full
	assign full = count[$clog2(DEPTH)];
	assign out_valid = |count;
	assign out_data = mem[rd_ptr];

	// Writes while full are lost
	assign wr_en = in_latch && !full;
	assign rd_en = out_latch && out_valid;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- source/ice_bus_controller.sv
`timescale 1ns/1ps

module ice_bus_controller import ice_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [7:0] rx_char,
	input logic rx_char_valid,
	output logic [7:0] tx_char,
	output logic tx_char_valid,
	input logic tx_char_ready,
	output logic [7:0] ma_addr,
	output logic [7:0] ma_id,
	output logic [7:0] ma_data,
	output logic ma_data_valid,
	output logic ma_frame_valid,
	input logic [NUM_SLAVES-1:0] sl_arb_request,
	output logic [NUM_SLAVES-1:0] sl_arb_grant,
	input logic [NUM_SLAVES*8-1:0] sl_type,
	input logic [NUM_SLAVES*8-1:0] sl_id,
	input logic [NUM_SLAVES*8-1:0] sl_len,
	input logic [NUM_SLAVES*8-1:0] sl_data,
	output logic [NUM_SLAVES-1:0] sl_take
);

	typedef enum logic [2:0] {P_TYPE, P_ID, P_LEN, P_DATA, P_END, P_SETTLE, P_DROP} p_state_t;
	typedef enum logic [2:0] {R_IDLE, R_TYPE, R_ID, R_LEN, R_DATA} r_state_t;

	p_state_t p_state;
	r_state_t rep_state;
	logic [7:0] fifo_data;
	logic fifo_valid;
	logic fifo_pop;
	logic [7:0] p_left;
	logic nak_pending;
	logic nak_start;
	logic bus_idle;
	logic known_type;

	logic rep_nak;
	logic [$clog2(NUM_SLAVES)-1:0] rep_sel;
	logic [$clog2(NUM_SLAVES)-1:0] req_sel;
	logic [7:0] rep_left;
	logic [7:0] cur_type;
	logic [7:0] cur_id;
	logic [7:0] cur_len;
	logic take_now;

	// Host bytes queue up while replies drain
	sync_fifo #(.payload_t(logic [7:0]), .DEPTH(RX_FIFO_DEPTH)) rx_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(rx_char),
		.in_latch(rx_char_valid),
		.out_data(fifo_data),
		.out_latch(fifo_pop),
		.out_valid(fifo_valid),
		.full()
	);

	assign known_type = (ma_addr == TYPE_VERSION) || (ma_addr == TYPE_POWER) ||
		(ma_addr == TYPE_GPIO);
	// New frame only once every earlier reply is out
	assign bus_idle = (rep_state == R_IDLE) && !nak_pending && !(|sl_arb_request);
	assign nak_start = (rep_state == R_IDLE) && nak_pending;

	always_comb begin
		case (p_state)
			P_TYPE: fifo_pop = fifo_valid && bus_idle;
			P_ID, P_LEN, P_DATA, P_DROP: fifo_pop = fifo_valid;
			default: fifo_pop = 1'b0;
		endcase
	end

	// Frame parser
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			p_state <= P_TYPE;
			p_left <= '0;
			ma_data_valid <= 1'b0;
			ma_frame_valid <= 1'b0;
			nak_pending <= 1'b0;
		end else begin
			ma_data_valid <= 1'b0;
			if (nak_start)
				nak_pending <= 1'b0;
			case (p_state)
				P_TYPE: begin
					if (fifo_pop) begin
						ma_addr <= fifo_data;
						p_state <= P_ID;
					end
				end
				P_ID: begin
					if (fifo_pop) begin
						ma_id <= fifo_data;
						p_state <= P_LEN;
					end
				end
				P_LEN: begin
					if (fifo_pop) begin
						p_left <= fifo_data;
						if (fifo_data > MAX_PAYLOAD) begin
							// Too long, drain it without a bus frame
							nak_pending <= 1'b1;
							p_state <= P_DROP;
						end else begin
							ma_frame_valid <= 1'b1;
							p_state <= (fifo_data == 8'd0) ? P_END : P_DATA;
						end
					end
				end
				P_DATA: begin
					if (fifo_pop) begin
						ma_data <= fifo_data;
						ma_data_valid <= 1'b1;
						p_left <= p_left - 1'b1;
						if (p_left == 8'd1)
							p_state <= P_END;
					end
				end
				P_END: begin
					// Frame valid covers the last data strobe, falls here
					ma_frame_valid <= 1'b0;
					if (!known_type)
						nak_pending <= 1'b1;
					p_state <= P_SETTLE;
				end
				P_SETTLE: begin
					// Responders raise their request this cycle
					p_state <= P_TYPE;
				end
				default: begin
					if (fifo_pop) begin
						p_left <= p_left - 1'b1;
						if (p_left == 8'd1)
							p_state <= P_TYPE;
					end
				end
			endcase
		end
	end

	// Lowest index requester wins
	always_comb begin
		req_sel = '0;
		for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
			if (sl_arb_request[i])
				req_sel = $bits(req_sel)'(i);
		end
	end

	// NAK id is ma_id, held since the parser waits for the reply
	assign cur_type = rep_nak ? TYPE_NAK : sl_type[8*rep_sel +: 8];
	assign cur_id = rep_nak ? ma_id : sl_id[8*rep_sel +: 8];
	assign cur_len = rep_nak ? 8'h00 : sl_len[8*rep_sel +: 8];

	always_comb begin
		case (rep_state)
			R_TYPE: tx_char = cur_type;
			R_ID: tx_char = cur_id;
			R_LEN: tx_char = cur_len;
			default: tx_char = sl_data[8*rep_sel +: 8];
		endcase
	end

	assign tx_char_valid = (rep_state != R_IDLE) && tx_char_ready;

	// One take per payload byte
	// An empty reply takes once on its length byte so the last take always ends it
	assign take_now = tx_char_valid && !rep_nak &&
		((rep_state == R_DATA) || ((rep_state == R_LEN) && (cur_len == 8'h00)));
	assign sl_take = take_now ? sl_arb_grant : '0;

	// Reply serializer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rep_state <= R_IDLE;
			rep_nak <= 1'b0;
			rep_sel <= '0;
			rep_left <= '0;
			sl_arb_grant <= '0;
		end else begin
			case (rep_state)
				R_IDLE: begin
					// Own NAK beats slave grants
					if (nak_start) begin
						rep_nak <= 1'b1;
						rep_state <= R_TYPE;
					end else if (|sl_arb_request) begin
						rep_nak <= 1'b0;
						rep_sel <= req_sel;
						sl_arb_grant <= NUM_SLAVES'(1) << req_sel;
						rep_state <= R_TYPE;
					end
				end
				R_TYPE: if (tx_char_ready) rep_state <= R_ID;
				R_ID: if (tx_char_ready) rep_state <= R_LEN;
				R_LEN: begin
					if (tx_char_ready) begin
						rep_left <= cur_len;
						if (cur_len == 8'h00) begin
							sl_arb_grant <= '0;
							rep_state <= R_IDLE;
						end else begin
							rep_state <= R_DATA;
						end
					end
				end
				default: begin
					if (tx_char_ready) begin
						rep_left <= rep_left - 1'b1;
						if (rep_left == 8'd1) begin
							sl_arb_grant <= '0;
							rep_state <= R_IDLE;
						end
					end
				end
			endcase
		end
	end

endmodule

//--- source/basics_int.sv
`timescale 1ns/1ps

module basics_int import ice_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [7:0] ma_addr,
	input logic [7:0] ma_id,
	input logic [7:0] ma_data,
	input logic ma_data_valid,
	input logic ma_frame_valid,
	output logic sl_arb_request,
	input logic sl_arb_grant,
	input logic sl_take,
	output logic [7:0] sl_type,
	output logic [7:0] sl_id,
	output logic [7:0] sl_len,
	output logic [7:0] sl_data,
	output logic m3_vbatt_sw,
	output logic m3_1p2_sw,
	output logic m3_0p6_sw
);

	logic fv_q;
	logic frame_end;
	logic first_seen;
	logic [2:0] pwr_bits;
	logic rd_idx;

	assign frame_end = fv_q && !ma_frame_valid;

	// Every answer here is an ACK
	assign sl_type = TYPE_ACK;
	// Version bytes, major first
	assign sl_data = !sl_arb_grant ? 8'h00 : (rd_idx ? VERSION_MINOR : VERSION_MAJOR);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fv_q <= 1'b0;
			first_seen <= 1'b0;
			rd_idx <= 1'b0;
			sl_arb_request <= 1'b0;
			{m3_vbatt_sw, m3_1p2_sw, m3_0p6_sw} <= 3'b000;
		end else begin
			fv_q <= ma_frame_valid;
			// Keep only the first payload byte
			if (ma_frame_valid && !fv_q) begin
				first_seen <= 1'b0;
			end else if (ma_data_valid && !first_seen) begin
				first_seen <= 1'b1;
				pwr_bits <= ma_data[2:0];
			end
			if (frame_end && ((ma_addr == TYPE_VERSION) || (ma_addr == TYPE_POWER))) begin
				sl_arb_request <= 1'b1;
				sl_id <= ma_id;
				rd_idx <= 1'b0;
				if (ma_addr == TYPE_VERSION) begin
					sl_len <= 8'd2;
				end else begin
					sl_len <= 8'd0;
					// Empty power frame leaves the switches alone
					if (first_seen)
						{m3_vbatt_sw, m3_1p2_sw, m3_0p6_sw} <= pwr_bits;
				end
			end else if (sl_take && sl_arb_grant) begin
				rd_idx <= 1'b1;
				if ((sl_len == 8'd0) || rd_idx)
					sl_arb_request <= 1'b0;
			end
		end
	end

endmodule

//--- source/gpio_int.sv
`timescale 1ns/1ps

module gpio_int import ice_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [7:0] ma_addr,
	input logic [7:0] ma_id,
	input logic [7:0] ma_data,
	input logic ma_data_valid,
	input logic ma_frame_valid,
	input logic [GPIO_WIDTH-1:0] gpio_in,
	output logic [GPIO_WIDTH-1:0] gpio_out,
	output logic [GPIO_WIDTH-1:0] gpio_oe,
	output logic sl_arb_request,
	input logic sl_arb_grant,
	input logic sl_take,
	output logic [7:0] sl_type,
	output logic [7:0] sl_id,
	output logic [7:0] sl_len,
	output logic [7:0] sl_data
);

	logic fv_q;
	logic gpio_end;
	logic [1:0] byte_cnt;
	logic [GPIO_WIDTH-1:0] oe_nxt;
	logic [GPIO_WIDTH-1:0] out_nxt;
	logic ack_pending;
	logic [7:0] ack_id;
	logic [1:0][GPIO_WIDTH-1:0] pin_sync;
	logic [GPIO_WIDTH-1:0] pin_prev;
	logic [GPIO_WIDTH-1:0] pin_chg;
	logic [7:0] event_ctr;
	gpio_event_t ev_in;
	gpio_event_t ev_head;
	logic ev_valid;
	logic ev_full;

	assign gpio_end = fv_q && !ma_frame_valid && (ma_addr == TYPE_GPIO);

	// Only input-direction pins count
	assign pin_chg = (pin_sync[1] ^ pin_prev) & ~gpio_oe;
	assign ev_in[1] = event_ctr + 1'b1;
	assign ev_in[0] = pin_sync[1] & ~gpio_oe;

	sync_fifo #(.payload_t(gpio_event_t), .DEPTH(EVENT_FIFO_DEPTH)) ev_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(ev_in),
		.in_latch((|pin_chg) && !ev_full),
		.out_data(ev_head),
		.out_latch(sl_take && sl_arb_grant && (sl_type == TYPE_EVENT)),
		.out_valid(ev_valid),
		.full(ev_full)
	);

	// Pin byte of the head event, only while granted
	assign sl_data = (sl_arb_grant && (sl_type == TYPE_EVENT)) ? ev_head[0] : 8'h00;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pin_sync <= '0;
			pin_prev <= '0;
			event_ctr <= '0;
		end else begin
			pin_sync <= {pin_sync[0], gpio_in};
			pin_prev <= pin_sync[1];
			// Counter moves even when the FIFO drops the event
			if (|pin_chg)
				event_ctr <= event_ctr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fv_q <= 1'b0;
			byte_cnt <= '0;
			gpio_oe <= '0;
			gpio_out <= '0;
			ack_pending <= 1'b0;
			sl_arb_request <= 1'b0;
		end else begin
			fv_q <= ma_frame_valid;
			if (ma_frame_valid && !fv_q) begin
				byte_cnt <= '0;
			end else if (ma_data_valid && (byte_cnt != 2'd2)) begin
				byte_cnt <= byte_cnt + 1'b1;
				if (byte_cnt == 2'd0)
					oe_nxt <= ma_data;
				else
					out_nxt <= ma_data;
			end
			// Registers follow only the bytes actually sent
			if (gpio_end && (byte_cnt != 2'd0))
				gpio_oe <= oe_nxt;
			if (gpio_end && (byte_cnt == 2'd2))
				gpio_out <= out_nxt;
			if (sl_arb_request) begin
				// Both reply kinds end on a single take
				if (sl_take && sl_arb_grant)
					sl_arb_request <= 1'b0;
				// ACK behind an event in flight
				if (gpio_end) begin
					ack_pending <= 1'b1;
					ack_id <= ma_id;
				end
			end else if (gpio_end || ack_pending) begin
				sl_arb_request <= 1'b1;
				sl_type <= TYPE_ACK;
				sl_id <= gpio_end ? ma_id : ack_id;
				sl_len <= 8'd0;
				ack_pending <= 1'b0;
			end else if (ev_valid) begin
				sl_arb_request <= 1'b1;
				sl_type <= TYPE_EVENT;
				sl_id <= ev_head[1];
				sl_len <= 8'd1;
			end
		end
	end

endmodule

//--- source/ice_bus.sv
`timescale 1ns/1ps

module ice_bus import ice_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic uart_rx,
	output logic uart_tx,
	input logic [GPIO_WIDTH-1:0] gpio_in,
	output logic [GPIO_WIDTH-1:0] gpio_out,
	output logic [GPIO_WIDTH-1:0] gpio_oe,
	output logic m3_vbatt_sw,
	output logic m3_1p2_sw,
	output logic m3_0p6_sw
);

	logic [7:0] uart_rx_data;
	logic [7:0] uart_tx_data;
	logic uart_rx_latch;
	logic uart_tx_latch;
	logic uart_tx_empty;

	// Master bus
	logic [7:0] ma_addr;
	logic [7:0] ma_id;
	logic [7:0] ma_data;
	logic ma_data_valid;
	logic ma_frame_valid;

	// Slave bus, one byte lane per responder
	logic [NUM_SLAVES-1:0] sl_arb_request;
	logic [NUM_SLAVES-1:0] sl_arb_grant;
	logic [NUM_SLAVES-1:0] sl_take;
	logic [NUM_SLAVES*8-1:0] sl_type;
	logic [NUM_SLAVES*8-1:0] sl_id;
	logic [NUM_SLAVES*8-1:0] sl_len;
	logic [NUM_SLAVES*8-1:0] sl_data;

	uart u1 (
		.clk(clk),
		.rst_n(rst_n),
		.rx_in(uart_rx),
		.tx_out(uart_tx),
		.tx_latch(uart_tx_latch),
		.tx_data(uart_tx_data),
		.tx_empty(uart_tx_empty),
		.rx_data(uart_rx_data),
		.rx_latch(uart_rx_latch)
	);

	ice_bus_controller ice1 (
		.clk(clk),
		.rst_n(rst_n),
		.rx_char(uart_rx_data),
		.rx_char_valid(uart_rx_latch),
		.tx_char(uart_tx_data),
		.tx_char_valid(uart_tx_latch),
		.tx_char_ready(uart_tx_empty),
		.ma_addr(ma_addr),
		.ma_id(ma_id),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.sl_arb_request(sl_arb_request),
		.sl_arb_grant(sl_arb_grant),
		.sl_type(sl_type),
		.sl_id(sl_id),
		.sl_len(sl_len),
		.sl_data(sl_data),
		.sl_take(sl_take)
	);

	// Index 0, highest priority
	basics_int bi0 (
		.clk(clk),
		.rst_n(rst_n),
		.ma_addr(ma_addr),
		.ma_id(ma_id),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.sl_arb_request(sl_arb_request[0]),
		.sl_arb_grant(sl_arb_grant[0]),
		.sl_take(sl_take[0]),
		.sl_type(sl_type[7:0]),
		.sl_id(sl_id[7:0]),
		.sl_len(sl_len[7:0]),
		.sl_data(sl_data[7:0]),
		.m3_vbatt_sw(m3_vbatt_sw),
		.m3_1p2_sw(m3_1p2_sw),
		.m3_0p6_sw(m3_0p6_sw)
	);

	gpio_int gi1 (
		.clk(clk),
		.rst_n(rst_n),
		.ma_addr(ma_addr),
		.ma_id(ma_id),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe),
		.sl_arb_request(sl_arb_request[1]),
		.sl_arb_grant(sl_arb_grant[1]),
		.sl_take(sl_take[1]),
		.sl_type(sl_type[15:8]),
		.sl_id(sl_id[15:8]),
		.sl_len(sl_len[15:8]),
		.sl_data(sl_data[15:8])
	);

endmodule

//--- test/ice_bus_tb.sv
`timescale 1ns/1ps

module ice_bus_tb import ice_pkg::*; ();

	// Byte 0 type, 1 id, 2 length, 3 and up payload
	typedef logic [18:0][7:0] frame_t;

	localparam int REPLY_TIMEOUT = 20000;
	localparam int QUIET_CYCLES = 3000;
	localparam int MAX_SENT = 16;

	logic clk;
	logic rst_n;
	logic uart_rx;
	logic uart_tx;
	logic [GPIO_WIDTH-1:0] gpio_in;
	logic [GPIO_WIDTH-1:0] gpio_out;
	logic [GPIO_WIDTH-1:0] gpio_oe;
	logic m3_vbatt_sw;
	logic m3_1p2_sw;
	logic m3_0p6_sw;

	frame_t exp_q [$];
	frame_t act_q [$];
	int exp_count = 0;
	int checked_count = 0;
	int err_count = 0;
	int check_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_err_base = 0;
	string test_name;

	// Host-side model of the DUT registers
	logic [2:0] model_pwr;
	logic [7:0] model_oe;
	logic [7:0] model_out;
	logic [7:0] model_ctr;
	logic [7:0] model_pins;

	ice_bus UUT (
		.clk(clk),
		.rst_n(rst_n),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe),
		.m3_vbatt_sw(m3_vbatt_sw),
		.m3_1p2_sw(m3_1p2_sw),
		.m3_0p6_sw(m3_0p6_sw)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
		end
	endtask

	// Expected reply to one host frame and its register model update
	function automatic frame_t expect_reply(input frame_t sent);
		frame_t r;
		r = '0;
		r[1] = sent[1];
		if ((sent[2] > 8'd8) ||
			!((sent[0] == 8'h56) || (sent[0] == 8'h70) || (sent[0] == 8'h67))) begin
			r[0] = 8'h01;
			return r;
		end
		r[0] = 8'h00;
		if (sent[0] == 8'h56) begin
			r[2] = 8'd2;
			r[3] = 8'h03;
			r[4] = 8'h01;
		end else if (sent[0] == 8'h70) begin
			if (sent[2] != 8'd0)
				model_pwr = sent[3][2:0];
		end else begin
			// Direction first, then level
			if (sent[2] >= 8'd1)
				model_oe = sent[3];
			if (sent[2] >= 8'd2)
				model_out = sent[4];
		end
		return r;
	endfunction

	// Event frame for a pin change with the next counter value as tag
	function automatic frame_t expect_event(input logic [7:0] pins);
		frame_t r;
		gpio_event_t ev;
		r = '0;
		model_ctr = model_ctr + 8'd1;
		ev[1] = model_ctr;
		ev[0] = pins & ~model_oe;
		r[0] = 8'h65;
		r[1] = ev[1];
		r[2] = 8'd1;
		r[3] = ev[0];
		return r;
	endfunction

	function automatic frame_t build_frame(input logic [7:0] t, input logic [7:0] id,
		input logic [7:0] len);
		frame_t f;
		f = '0;
		f[0] = t;
		f[1] = id;
		f[2] = len;
		for (int i = 0; i < MAX_SENT; i++)
			f[3 + i] = 8'($urandom);
		return f;
	endfunction

	function automatic logic [7:0] unknown_type();
		logic [7:0] t;
		t = 8'($urandom);
		while ((t == 8'h56) || (t == 8'h70) || (t == 8'h67))
			t = 8'($urandom);
		return t;
	endfunction

	// 8N1 with LSB first, starting from a falling edge
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rx = bits[i];
			repeat (CLKS_PER_BIT) @(negedge clk);
		end
	endtask

	task automatic send_frame(input frame_t f);
		send_byte(f[0]);
		send_byte(f[1]);
		send_byte(f[2]);
		for (int i = 0; i < int'(f[2]); i++)
			send_byte(f[3 + i]);
	endtask

	// Queue the prediction before sending
	task automatic run_frame(input frame_t f);
		exp_q.push_back(expect_reply(f));
		exp_count++;
		send_frame(f);
	endtask

	task automatic drive_pins(input logic [7:0] pins);
		if (((pins ^ model_pins) & ~model_oe) != 8'h00) begin
			exp_q.push_back(expect_event(pins));
			exp_count++;
		end
		@(negedge clk);
		gpio_in = pins;
		model_pins = pins;
	endtask

	task automatic wait_replies();
		int cycles;
		cycles = 0;
		while ((checked_count != exp_count) && (cycles < REPLY_TIMEOUT)) begin
			@(negedge clk);
			cycles++;
		end
		if (checked_count != exp_count) begin
			err_count++;
			$display("Timeout in %s, %0d reply frames still missing", test_name,
				exp_count - checked_count);
			// Drop stale frames so later tests pair up again
			exp_q.delete();
			act_q.delete();
			checked_count = exp_count;
		end
	endtask

	// Nothing may come out of uart_tx for a while
	task automatic expect_silence();
		repeat (QUIET_CYCLES) @(negedge clk);
		check("unexpected reply frames", 8'(act_q.size()), 8'd0);
	endtask

	task automatic check_outputs();
		check("m3 switches", {5'd0, m3_vbatt_sw, m3_1p2_sw, m3_0p6_sw}, {5'd0, model_pwr});
		check("gpio_oe", gpio_oe, model_oe);
		check("gpio_out", gpio_out, model_out);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err_base = err_count;
	endtask

	task automatic end_test();
		check("extra reply frames", 8'(act_q.size()), 8'd0);
		tests_run++;
		if (err_count != test_err_base) begin
			tests_failed++;
			$display("test %0d %s: FAILED with %0d errors", tests_run, test_name,
				err_count - test_err_base);
		end else begin
			$display("test %0d %s: ok", tests_run, test_name);
		end
	endtask

	// Mid-bit sampling from the first low edge seen
	task automatic recv_byte(output logic [7:0] b);
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		if (uart_tx !== 1'b0) begin
			err_count++;
			$display("uart_tx start bit did not stay low until mid-bit");
		end
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			b[i] = uart_tx;
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		if (uart_tx !== 1'b1) begin
			err_count++;
			$display("uart_tx stop bit missing after byte 0x%02h", b);
		end
	endtask

	// Decodes uart_tx bytes into whole frames
	initial begin : monitor_tx
		frame_t cur;
		int idx;
		logic [7:0] b;
		cur = '0;
		idx = 0;
		forever begin
			@(negedge clk);
			if (uart_tx === 1'b0) begin
				recv_byte(b);
				cur[idx] = b;
				idx++;
				if (((idx >= 3) && (idx == 3 + int'(cur[2]))) || (idx == 19)) begin
					act_q.push_back(cur);
					cur = '0;
					idx = 0;
				end
			end
		end
	end

	// Pairs predicted and decoded frames in order
	initial begin : compare_replies
		frame_t exp_f;
		frame_t act_f;
		forever begin
			@(negedge clk);
			if ((exp_q.size() > 0) && (act_q.size() > 0)) begin
				exp_f = exp_q.pop_front();
				act_f = act_q.pop_front();
				check("reply type", act_f[0], exp_f[0]);
				check("reply id", act_f[1], exp_f[1]);
				check("reply length", act_f[2], exp_f[2]);
				for (int i = 0; i < 8; i++)
					check($sformatf("reply payload[%0d]", i), act_f[3 + i], exp_f[3 + i]);
				checked_count++;
			end
		end
	end

	initial begin : stimulus
		frame_t f;
		logic [7:0] pins;
		logic [7:0] mask;
		void'($urandom(32'h56c273cd));
		rst_n = 1'b0;
		uart_rx = 1'b1;
		gpio_in = '0;
		model_pwr = 3'b000;
		model_oe = 8'h00;
		model_out = 8'h00;
		model_ctr = 8'h00;
		model_pins = 8'h00;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		begin_test("reset state");
		check("uart_tx", {7'd0, uart_tx}, 8'h01);
		check_outputs();
		end_test();

		begin_test("version query");
		for (int i = 0; i < 3; i++) begin
			run_frame(build_frame(TYPE_VERSION, 8'($urandom), 8'd0));
			wait_replies();
		end
		end_test();

		begin_test("power switches");
		for (int i = 0; i < 4; i++) begin
			run_frame(build_frame(TYPE_POWER, 8'($urandom), 8'd1));
			wait_replies();
			check_outputs();
		end
		end_test();

		begin_test("nak on unknown type and long payload");
		for (int i = 0; i < 3; i++) begin
			run_frame(build_frame(unknown_type(), 8'($urandom), 8'($urandom % 9)));
			wait_replies();
			check_outputs();
		end
		run_frame(build_frame(TYPE_POWER, 8'($urandom), 8'(9 + $urandom % 8)));
		wait_replies();
		check_outputs();
		run_frame(build_frame(TYPE_GPIO, 8'($urandom), 8'(9 + $urandom % 8)));
		wait_replies();
		check_outputs();
		end_test();

		begin_test("gpio register and input events");
		f = build_frame(TYPE_GPIO, 8'($urandom), 8'd2);
		// Mixed directions so both pin kinds get exercised
		if ((f[3] == 8'h00) || (f[3] == 8'hff))
			f[3] = 8'h3c;
		run_frame(f);
		wait_replies();
		check_outputs();
		for (int i = 0; i < 8; i++) begin
			pins = 8'($urandom);
			drive_pins(pins);
			if (exp_count != checked_count)
				wait_replies();
			else
				expect_silence();
		end
		// Output-direction pins only
		mask = model_oe & 8'($urandom);
		if (mask == 8'h00)
			mask = model_oe;
		drive_pins(model_pins ^ mask);
		expect_silence();
		end_test();

		begin_test("back to back frames");
		run_frame(build_frame(TYPE_VERSION, 8'($urandom), 8'd0));
		run_frame(build_frame(TYPE_POWER, 8'($urandom), 8'd1));
		run_frame(build_frame(unknown_type(), 8'($urandom), 8'd1));
		run_frame(build_frame(TYPE_GPIO, 8'($urandom), 8'd2));
		run_frame(build_frame(TYPE_VERSION, 8'($urandom), 8'd0));
		wait_replies();
		check_outputs();
		end_test();

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
			check_count, err_count);
		if (err_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- ice_bus.f
source/ice_pkg.sv
source/uart.sv
source/sync_fifo.sv
source/ice_bus_controller.sv
source/basics_int.sv
source/gpio_int.sv
source/ice_bus.sv
test/ice_bus_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the ice_bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 --top-module ice_bus_tb -f ice_bus.f -o ice_bus_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/ice_bus_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
	echo "No pass line found in $LOG"
	exit 1
fi
exit 0
